//--- verilog.f
+incdir+source
source/tankPkg.sv
source/keyDecoder.sv
source/trigTable.sv
source/tankMotion.sv
source/poseSender.sv
source/tankTop.sv
testbench/tank_checker.sv
testbench/tankTb.sv

//--- Makefile
# Verilator build and run of the tank motion testbench

VERILATOR ?= verilator
TOP       ?= tankTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulation reads source/sinTable.hex, so it runs from the project root
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- source/sinTable.hex
// One signed Q1.7 sine sample per line, heading index 0 to 39 in 9 degree steps
00
14
27
3a
4b
5a
67
71
79
7d
7f
7d
79
71
67
5a
4b
3a
27
14
00
ec
d9
c6
b5
a6
99
8f
87
83
81
83
87
8f
99
a6
b5
c6
d9
ec

//--- testbench/tankTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_defines.svh"

module tankTb;
    import tankPkg::*;

    localparam int resetCycles   = 16;
    localparam int randomFrames  = 2000;
    localparam int blockFrames   = 100;                   // Frames per stimulus mode
    localparam int maxAckDelay   = 5;
    localparam int idleWindow    = 10;                    // Quiet cycles that end the drain
    localparam int handshakeMax  = 2 * (maxAckDelay + 2); // Longest req/ack round
    localparam int timeoutCycles = resetCycles + randomFrames + 2 + 3 * handshakeMax
                                   + idleWindow + 20;
    localparam logic [7:0]  codeForward = 8'h52;
    localparam logic [7:0]  codeBack    = 8'h51;
    localparam logic [7:0]  codeLeft    = 8'h50;
    localparam logic [7:0]  codeRight   = 8'h4f;
    localparam logic [31:0] arrowCodes  = {codeRight, codeLeft, codeBack, codeForward};
    localparam pose_t       centerPose  = '{`TANK_X_CENTER, `TANK_Y_CENTER, 6'd0};

    logic        Reset;        // Clock
    logic        frame_clk;    // Reset
    logic [31:0] keycode;
    logic        ack;
    pose_t       pose;
    pose_t       reportPose;
    logic        req;

    logic signed [7:0] sinModel [0:`TANK_ANGLE_STEPS-1];  // Own copy of the table
    keyCmd_t     modelCmd;      // Model decoder stage
    pose_t       modelPose;     // Model motion stage
    pose_t       modelNext;
    pose_t       history [$];   // Changed poses in order
    pose_t       lastReport;
    int          seed;
    int          cycleCount;
    int          reportCount;
    int          ackWait;       // Cycles left before the responder moves
    int          quietCycles;
    logic        ackNext;
    logic [7:0]  heldCode;
    logic [31:0] nextKeys;

    tankTop tankTop_inst
    (
        .Reset      (Reset),
        .frame_clk  (frame_clk),
        .keycode    (keycode),
        .ack        (ack),
        .pose       (pose),
        .reportPose (reportPose),
        .req        (req)
    );

    bind tankTop tank_checker tank_checker_inst
    (
        .Reset      (Reset),
        .frame_clk  (frame_clk),
        .pose       (pose),
        .reportPose (reportPose),
        .req        (req),
        .ack        (ack)
    );

    always #20 Reset = ~Reset;  // 40 ns period

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic hasCode(input logic [31:0] codes, input logic [7:0] code);
        return (codes[7:0] == code) || (codes[15:8] == code)
            || (codes[23:16] == code) || (codes[31:24] == code);
    endfunction

    function automatic keyCmd_t decodeKeys(input logic [31:0] codes);
        if (hasCode(codes, codeForward))
            return cmdForward;
        else if (hasCode(codes, codeBack))
            return cmdBack;
        else if (hasCode(codes, codeLeft))
            return cmdLeft;
        else if (hasCode(codes, codeRight))
            return cmdRight;
        return cmdNone;
    endfunction

    function automatic logic [9:0] clampModel(input int value, input int maxVal);
        int lowLimit;
        int highLimit;
        lowLimit  = `TANK_SIZE;
        highLimit = maxVal - `TANK_SIZE;
        if (value < lowLimit)
            value = lowLimit;
        else if (value > highLimit)
            value = highLimit;
        return 10'(value);
    endfunction

    function automatic pose_t stepPose(input pose_t cur, input keyCmd_t c);
        pose_t nxt;
        int    cosIdx;
        int    dx;
        int    dy;
        int    dir;
        nxt    = cur;
        cosIdx = (int'(cur.angle) + 10) % `TANK_ANGLE_STEPS;   // cos as shifted sine
        dx     = (int'(`TANK_STEP) * int'(sinModel[cosIdx])) >>> 7;
        dy     = (int'(`TANK_STEP) * int'(sinModel[cur.angle])) >>> 7;
        dir    = (c == cmdForward) ? 1 : -1;
        case (c)
            cmdLeft:
                nxt.angle = (int'(cur.angle) == `TANK_ANGLE_STEPS - 1) ? 6'd0 : cur.angle + 6'd1;
            cmdRight:
                nxt.angle = (cur.angle == 6'd0) ? 6'(`TANK_ANGLE_STEPS - 1) : cur.angle - 6'd1;
            cmdForward, cmdBack:
            begin
                nxt.x = clampModel(int'(cur.x) + dir * dx, `TANK_X_MAX);
                nxt.y = clampModel(int'(cur.y) - dir * dy, `TANK_Y_MAX);  // Screen y down
            end
            default:
                nxt = cur;
        endcase
        return nxt;
    endfunction

    // Two stages like the DUT, one frame each
    always @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            modelCmd  <= cmdNone;
            modelPose <= centerPose;
        end
        else
        begin
            modelNext = stepPose(modelPose, modelCmd);
            if (modelNext != modelPose)
                history.push_back(modelNext);  // Every change the renderer may see
            modelCmd  <= decodeKeys(keycode);
            modelPose <= modelNext;
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic stopOnError();
        $display("test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic checkPose(input string testName, input pose_t expected, input pose_t actual);
        if (actual !== expected)
        begin
            $display("error %s expected x=%0d y=%0d angle=%0d actual x=%0d y=%0d angle=%0d",
                     testName, expected.x, expected.y, expected.angle,
                     actual.x, actual.y, actual.angle);
            stopOnError();
        end
    endtask

    task automatic checkReport(input string testName, input pose_t expected, input pose_t actual);
        if (actual !== expected)
        begin
            $display("error %s expected report x=%0d y=%0d angle=%0d actual x=%0d y=%0d angle=%0d",
                     testName, expected.x, expected.y, expected.angle,
                     actual.x, actual.y, actual.angle);
            stopOnError();
        end
    endtask

    task automatic checkReq(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("error %s expected req=%b actual req=%b", testName, expected, actual);
            stopOnError();
        end
    endtask

    // --------------------------------------------------
    // Stimulus and renderer side
    // --------------------------------------------------
    task automatic drawKeycode(input logic [7:0] held, output logic [31:0] codes);
        int pick;
        for (int i = 0; i < 4; i++)
        begin
            pick = $random(seed);
            if (pick[0] && held == 8'h00)
                codes[8*i +: 8] = arrowCodes[8*pick[2:1] +: 8];  // Arrow about half the time
            else
                codes[8*i +: 8] = pick[15:8];                    // Filler byte
        end
        if (held != 8'h00)
            codes[8*pick[17:16] +: 8] = held;                    // Held key in a random byte
    endtask

    task automatic drawDelay(output int delay);
        delay = {$random(seed)} % (maxAckDelay + 1);
    endtask

    // Report must be a later entry of the changed pose history
    task automatic matchReport(input pose_t got);
        while (history.size() > 0 && history[0] !== got)
            void'(history.pop_front());
        if (history.size() == 0)
        begin
            $display("reported pose x=%0d y=%0d angle=%0d is not a later model pose",
                     got.x, got.y, got.angle);
            stopOnError();
        end
        else
            void'(history.pop_front());  // Later reports must follow this entry
    endtask

    task automatic serveAck();
        ackNext = ack;
        if (req && !ack)
        begin
            if (ackWait == 0)
            begin
                ackNext    = 1'b1;
                matchReport(reportPose);
                lastReport = reportPose;
                reportCount++;
                drawDelay(ackWait);
            end
            else
                ackWait--;
        end
        else if (!req && ack)
        begin
            if (ackWait == 0)
            begin
                ackNext = 1'b0;   // Phase four
                drawDelay(ackWait);
            end
            else
                ackWait--;
        end
    endtask

    // Check at the falling edge, drive at the rising edge
    task automatic runFrame(input logic [31:0] keys);
        @(negedge Reset);
        checkPose("pose tracking", modelPose, pose);
        serveAck();
        quietCycles = (!req && !ack) ? quietCycles + 1 : 0;
        @(posedge Reset);
        keycode <= keys;
        ack     <= ackNext;
    endtask

    always @(posedge Reset)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("run did not finish within %0d cycles", timeoutCycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        seed        = 9;
        Reset       = 1'b0;
        frame_clk   = 1'b1;
        keycode     = 32'h0;
        ack         = 1'b0;
        ackNext     = 1'b0;
        ackWait     = 0;
        cycleCount  = 0;
        reportCount = 0;
        quietCycles = 0;
        lastReport  = centerPose;
        $readmemh("source/sinTable.hex", sinModel);

        repeat (resetCycles - 1) @(posedge Reset);
        @(negedge Reset);
        checkPose("reset pose", centerPose, pose);
        checkReq("reset req", 1'b0, req);
        @(posedge Reset);
        frame_clk <= 1'b0;

        // Mixed blocks turn and move, held blocks drive into the edges
        for (int f = 0; f < randomFrames; f++)
        begin
            case ((f / blockFrames) % 4)
                2:       heldCode = codeForward;
                3:       heldCode = codeBack;
                default: heldCode = 8'h00;
            endcase
            drawKeycode(heldCode, nextKeys);
            runFrame(nextKeys);
        end

        // Keys released, let the last reports drain
        quietCycles = 0;
        while (quietCycles < idleWindow)
            runFrame(32'h0);

        if (reportCount == 0)
        begin
            $display("no pose report completed during the run");
            stopOnError();
        end
        checkPose("final pose", modelPose, pose);
        checkReport("final report", modelPose, lastReport);
        if (tankTop_inst.tank_checker_inst.failCount == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            $display("test failed");
            $fatal(1, "handshake or field assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- testbench/tank_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_defines.svh"

module tank_checker
(
    input wire logic           Reset,       // Frame clock
    input wire logic           frame_clk,   // Async reset, active high
    input wire tankPkg::pose_t pose,        // Live pose
    input wire tankPkg::pose_t reportPose,  // Pose under handshake
    input wire logic           req,
    input wire logic           ack
);
    import tankPkg::*;

    localparam logic [9:0] xLow  = `TANK_SIZE;
    localparam logic [9:0] xHigh = `TANK_X_MAX - `TANK_SIZE;  // 623
    localparam logic [9:0] yLow  = `TANK_SIZE;
    localparam logic [9:0] yHigh = `TANK_Y_MAX - `TANK_SIZE;  // 463

    int failCount = 0;  // Assertion failures so far

    // --------------------------------------------------
    // Four phase handshake
    // --------------------------------------------------
    reqFallAfterAck: assert property (@(posedge Reset) disable iff (frame_clk)
        $fell(req) |-> $past(ack))
    else
    begin
        failCount++;
        $error("req dropped before ack was seen high");
    end

    reportStable: assert property (@(posedge Reset) disable iff (frame_clk)
        req |=> (!req || $stable(reportPose)))
    else
    begin
        failCount++;
        $error("reportPose changed while req was high");
    end

    reqRiseAckLow: assert property (@(posedge Reset) disable iff (frame_clk)
        $rose(req) |-> !$past(ack))
    else
    begin
        failCount++;
        $error("req rose while ack was still high");
    end

    // Body stays inside the visible field
    poseInField: assert property (@(posedge Reset) disable iff (frame_clk)
        (pose.x >= xLow) && (pose.x <= xHigh) && (pose.y >= yLow) && (pose.y <= yHigh)
        && (pose.angle < 6'(`TANK_ANGLE_STEPS)))
    else
    begin
        failCount++;
        $error("pose left the field limits");
    end

endmodule

`default_nettype wire

//--- source/tankTop.sv
`timescale 1ns/1ns
`default_nettype none

module tankTop
(
    input  wire logic        Reset,       // Frame clock
    input  wire logic        frame_clk,   // Async reset, active high
    input  wire logic [31:0] keycode,     // Four scan codes
    input  wire logic        ack,         // Renderer acknowledge
    output tankPkg::pose_t   pose,        // Live pose
    output tankPkg::pose_t   reportPose,  // Pose under handshake
    output logic             req          // Renderer request
);
    import tankPkg::*;

    keyCmd_t cmd;          // Decoder to motion
    trig_t   trig;         // Table to motion
    logic    poseChanged;  // Motion to sender

    keyDecoder keyDecoder_inst
    (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .cmd       (cmd)
    );

    trigTable trigTable_inst
    (
        .angle (pose.angle),  // Heading held before the frame
        .trig  (trig)
    );

    tankMotion tankMotion_inst
    (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .cmd         (cmd),
        .trig        (trig),
        .pose        (pose),
        .poseChanged (poseChanged)
    );

    poseSender poseSender_inst
    (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .pose        (pose),
        .poseChanged (poseChanged),
        .reportPose  (reportPose),
        .req         (req),
        .ack         (ack)
    );

endmodule

`default_nettype wire

//--- source/poseSender.sv
`timescale 1ns/1ns
`default_nettype none

module poseSender
(
    input  wire logic           Reset,        // Frame clock
    input  wire logic           frame_clk,    // Async reset, active high
    input  wire tankPkg::pose_t pose,         // Pose from motion
    input  wire logic           poseChanged,  // New pose this cycle
    output tankPkg::pose_t      reportPose,   // Held while req is high
    output logic                req,          // Four phase request
    input  wire logic           ack           // Renderer acknowledge
);
    import tankPkg::*;

    typedef enum logic [1:0]
    {
        stIdle,      // Nothing in flight
        stRequest,   // req high, waiting for ack
        stRelease    // req low, waiting for ack to drop
    } sendState_t;

    sendState_t state;
    sendState_t nextState;
    pose_t      pendPose;    // Newest pose seen while busy
    logic       pendValid;
    logic       loadOut;     // Start a report
    logic       holdPend;    // Park a pose in the slot

    assign loadOut  = (state == stIdle) && (poseChanged || pendValid);
    assign holdPend = (state != stIdle) && poseChanged;

    // --------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------
    always_comb
    begin
        nextState = state;
        case (state)
            stIdle:
                if (loadOut)
                    nextState = stRequest;
            stRequest:
                if (ack)
                    nextState = stRelease;  // Drop req next
            stRelease:
                if (!ack)
                    nextState = stIdle;     // Cycle complete
            default:
                nextState = stIdle;
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            state     <= stIdle;
            pendValid <= 1'b0;
        end
        else
        begin
            state <= nextState;
            if (holdPend)
                pendValid <= 1'b1;
            else if (loadOut)
                pendValid <= 1'b0;  // Slot consumed or superseded
        end
    end

    // Fresh pose wins over the parked one
    always_ff @(posedge Reset)
    begin
        if (loadOut)
            reportPose <= poseChanged ? pose : pendPose;
        if (holdPend)
            pendPose <= pose;       // Newer overwrites older
    end

    assign req = (state == stRequest);

endmodule

`default_nettype wire

//--- source/tankMotion.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_defines.svh"

module tankMotion
(
    input  wire logic             Reset,        // Frame clock
    input  wire logic             frame_clk,    // Async reset, active high
    input  wire tankPkg::keyCmd_t cmd,          // Decoded command
    input  wire tankPkg::trig_t   trig,         // Trig of the held heading
    output tankPkg::pose_t        pose,         // Current pose
    output logic                  poseChanged   // One cycle pulse on change
);
    import tankPkg::*;

    localparam logic [5:0] lastAngle = 6'(`TANK_ANGLE_STEPS - 1);

    logic signed [15:0] prodX;     // Step times cosine
    logic signed [15:0] prodY;     // Step times sine
    logic signed [11:0] stepX;     // Scaled back from Q1.7
    logic signed [11:0] stepY;
    logic signed [11:0] posX;      // Zero extended position
    logic signed [11:0] posY;
    logic signed [11:0] movX;      // Unclamped target
    logic signed [11:0] movY;
    pose_t              nextPose;

    // Keep a coordinate within SIZE and max minus SIZE
    function automatic logic [9:0] clampCoord
    (
        input logic signed [11:0] value,
        input logic        [9:0]  maxVal
    );
        logic signed [11:0] lowLimit;
        logic signed [11:0] highLimit;
        lowLimit  = $signed({2'b00, `TANK_SIZE});
        highLimit = $signed({2'b00, maxVal - `TANK_SIZE});
        if (value < lowLimit)
            return lowLimit[9:0];
        else if (value > highLimit)
            return highLimit[9:0];
        else
            return value[9:0];
    endfunction

    // --------------------------------------------------
    // Step scaling
    // --------------------------------------------------
    assign prodX = $signed({1'b0, `TANK_STEP}) * trig.cosVal;
    assign prodY = $signed({1'b0, `TANK_STEP}) * trig.sinVal;
    assign stepX = 12'(prodX >>> 7);  // Arithmetic shift keeps sign
    assign stepY = 12'(prodY >>> 7);
    assign posX  = $signed({2'b00, pose.x});
    assign posY  = $signed({2'b00, pose.y});

    // Screen y grows downward so forward subtracts dy
    always_comb
    begin
        case (cmd)
            cmdForward:
            begin
                movX = posX + stepX;
                movY = posY - stepY;
            end
            cmdBack:
            begin
                movX = posX - stepX;
                movY = posY + stepY;
            end
            default:
            begin
                movX = posX;
                movY = posY;
            end
        endcase
    end

    // --------------------------------------------------
    // Next pose
    // --------------------------------------------------
    always_comb
    begin
        nextPose = pose;
        case (cmd)
            cmdLeft:
                nextPose.angle = (pose.angle == lastAngle) ? 6'd0 : pose.angle + 6'd1;
            cmdRight:
                nextPose.angle = (pose.angle == 6'd0) ? lastAngle : pose.angle - 6'd1;
            cmdForward, cmdBack:
            begin
                nextPose.x = clampCoord(movX, `TANK_X_MAX);
                nextPose.y = clampCoord(movY, `TANK_Y_MAX);
            end
            default:
                nextPose = pose;  // Hold
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            pose        <= '{x: `TANK_X_CENTER, y: `TANK_Y_CENTER, angle: 6'd0};
            poseChanged <= 1'b0;
        end
        else
        begin
            pose        <= nextPose;
            poseChanged <= (nextPose != pose);  // Clamped moves may not change
        end
    end

endmodule

`default_nettype wire

//--- source/trigTable.sv
`timescale 1ns/1ns
`default_nettype none

`include "tank_defines.svh"

module trigTable
(
    input  wire logic [5:0] angle,  // Heading index
    output tankPkg::trig_t  trig    // Sine and cosine of the heading
);

    localparam logic [5:0] quarterTurn = 6'(`TANK_QUARTER_TURN);
    localparam logic [5:0] wrapPoint   = 6'(`TANK_ANGLE_STEPS - `TANK_QUARTER_TURN);

    logic signed [7:0] sinRom [0:`TANK_ANGLE_STEPS-1];  // One sample per step
    logic        [5:0] cosIndex;                        // Heading plus a quarter turn

    initial
    begin
        $readmemh("source/sinTable.hex", sinRom);  // Fixed contents
    end

    // cos(a) = sin(a + 10) with wrap at 40
    always_comb
    begin
        if (angle >= wrapPoint)
            cosIndex = angle - wrapPoint;
        else
            cosIndex = angle + quarterTurn;
    end

    assign trig.sinVal = sinRom[angle];
    assign trig.cosVal = sinRom[cosIndex];

endmodule

`default_nettype wire

//--- source/keyDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module keyDecoder
(
    input  wire logic        Reset,      // Frame clock
    input  wire logic        frame_clk,  // Async reset, active high
    input  wire logic [31:0] keycode,    // Four scan code bytes
    output tankPkg::keyCmd_t cmd         // Registered command
);
    import tankPkg::*;

    localparam logic [7:0] codeUp    = 8'h52;  // Forward
    localparam logic [7:0] codeDown  = 8'h51;  // Back
    localparam logic [7:0] codeLeft  = 8'h50;  // Turn left
    localparam logic [7:0] codeRight = 8'h4f;  // Turn right

    logic    [3:0] hitUp;     // One bit per byte
    logic    [3:0] hitDown;
    logic    [3:0] hitLeft;
    logic    [3:0] hitRight;
    keyCmd_t       nextCmd;   // Resolved before the register

    // Any of the four bytes may carry an arrow
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            hitUp[i]    = (keycode[8*i +: 8] == codeUp);
            hitDown[i]  = (keycode[8*i +: 8] == codeDown);
            hitLeft[i]  = (keycode[8*i +: 8] == codeLeft);
            hitRight[i] = (keycode[8*i +: 8] == codeRight);
        end
    end

    // Forward beats back beats left beats right
    always_comb
    begin
        if (|hitUp)
            nextCmd = cmdForward;
        else if (|hitDown)
            nextCmd = cmdBack;
        else if (|hitLeft)
            nextCmd = cmdLeft;
        else if (|hitRight)
            nextCmd = cmdRight;
        else
            nextCmd = cmdNone;
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
            cmd <= cmdNone;   // Idle after reset
        else
            cmd <= nextCmd;   // One command per frame
    end

endmodule

`default_nettype wire

//--- source/tankPkg.sv
`default_nettype none

package tankPkg;

    // One command per frame from the arrow keys
    typedef enum logic [2:0]
    {
        cmdNone    = 3'd0,  // No arrow held
        cmdForward = 3'd1,  // Up arrow
        cmdBack    = 3'd2,  // Down arrow
        cmdLeft    = 3'd3,  // Counter clockwise turn
        cmdRight   = 3'd4   // Clockwise turn
    } keyCmd_t;

    // Tank pose as seen by the renderer
    typedef struct packed
    {
        logic [9:0] x;      // Center column
        logic [9:0] y;      // Center row, grows downward
        logic [5:0] angle;  // Heading index 0 to 39
    } pose_t;

    // Table outputs for one heading
    typedef struct packed
    {
        logic signed [7:0] sinVal;  // Q1.7
        logic signed [7:0] cosVal;  // Q1.7
    } trig_t;

endpackage

`default_nettype wire

//--- source/tank_defines.svh
`ifndef TANK_DEFINES_SVH
`define TANK_DEFINES_SVH

// --------------------------------------------------
// Playfield
// --------------------------------------------------
`define TANK_X_CENTER     10'd300     // Start column
`define TANK_Y_CENTER     10'd250     // Start row
`define TANK_X_MAX        10'd639     // Rightmost visible column
`define TANK_Y_MAX        10'd479     // Bottom visible row

// --------------------------------------------------
// Tank geometry and motion
// --------------------------------------------------
`define TANK_SIZE         10'd16      // Half width, keeps the body on screen
`define TANK_STEP         8'd5        // Pixels per move at full scale
`define TANK_ANGLE_STEPS  40          // 9 degrees per heading step
`define TANK_QUARTER_TURN (`TANK_ANGLE_STEPS / 4) // Sine to cosine offset

`endif
